/* logic/pixelPipe_config.svh */
// Width and latency macros for the fragment pixel pipeline
`ifndef PIXELPIPE_CONFIG_SVH
`define PIXELPIPE_CONFIG_SVH

// Framebuffer addressing and stored depth
`define FB_INDEX_WIDTH 14
`define DEPTH_WIDTH 16

// One color channel in the framebuffer
`define SUB_PIXEL_WIDTH 8

// Incoming fixed point formats, unsigned 8.8 color and signed 8.16 depth
`define COLOR_IN_WIDTH 16
`define DEPTH_IN_WIDTH 24

// Edges from fragment acceptance to write-back
`define PIPE_LATENCY 5

`endif

/* logic/pixelPkg.sv */
// Pixel pipeline package: compare function enum, pixel, depth and index types
package pixelPkg;

`include "pixelPipe_config.svh"

    // Test functions shared by the alpha and depth tests
    typedef enum logic [2:0]
    {
        cmpNever,
        cmpLess,
        cmpEqual,
        cmpLessEqual,
        cmpGreater,
        cmpNotEqual,
        cmpGreaterEqual,
        cmpAlways
    } compareFuncE;

    // One framebuffer pixel, r in the top byte
    typedef struct packed
    {
        logic [`SUB_PIXEL_WIDTH-1:0] r;
        logic [`SUB_PIXEL_WIDTH-1:0] g;
        logic [`SUB_PIXEL_WIDTH-1:0] b;
        logic [`SUB_PIXEL_WIDTH-1:0] a;
    } pixelT;

    typedef logic [`DEPTH_WIDTH-1:0] depthT;
    typedef logic [`FB_INDEX_WIDTH-1:0] fbIndexT;

endpackage

/* logic/fragmentIf.sv */
// Fragment interface between the clamp stage and the test stages
interface fragmentIf;

    // Single cycle strobe, no back-pressure
    logic valid;
    pixelPkg::fbIndexT fbIndex;
    pixelPkg::depthT depth;
    pixelPkg::pixelT color;

    modport src
    (
        output valid,
        output fbIndex,
        output depth,
        output color
    );

    modport dst
    (
        input valid,
        input fbIndex,
        input depth,
        input color
    );

endinterface

/* logic/fragmentClamp.sv */
// Input stage: depth and color clamping, depth buffer read address
`include "pixelPipe_config.svh"

module fragmentClamp
(
    input  logic clk,
    input  logic reset,
    input  logic fragValid,
    input  pixelPkg::fbIndexT fragIndex,
    input  logic [`DEPTH_IN_WIDTH-1:0] fragDepth,
    input  logic [`COLOR_IN_WIDTH-1:0] fragR,
    input  logic [`COLOR_IN_WIDTH-1:0] fragG,
    input  logic [`COLOR_IN_WIDTH-1:0] fragB,
    input  logic [`COLOR_IN_WIDTH-1:0] fragA,
    output pixelPkg::fbIndexT depthIndexRead,
    fragmentIf.src out
);

    ////////////////////
    // Clamp helpers
    ////////////////////

    // Negative goes to 0, anything at or above 1.0 saturates
    function automatic pixelPkg::depthT clampDepth(input logic [`DEPTH_IN_WIDTH-1:0] z);
        if (z[`DEPTH_IN_WIDTH-1])
            return '0;
        else if (|z[`DEPTH_IN_WIDTH-2:`DEPTH_WIDTH])
            return '1;
        else
            return z[`DEPTH_WIDTH-1:0];
    endfunction

    // 8.8 channel down to its fraction byte
    function automatic logic [`SUB_PIXEL_WIDTH-1:0] clampColor(
        input logic [`COLOR_IN_WIDTH-1:0] c
    );
        if (|c[`COLOR_IN_WIDTH-1:`SUB_PIXEL_WIDTH])
            return '1;
        else
            return c[`SUB_PIXEL_WIDTH-1:0];
    endfunction

    ////////////////////
    // Stage register
    ////////////////////

    // Payload and read address only load on a strobe
    always_ff @(posedge clk)
    begin
        if (fragValid)
        begin
            out.fbIndex <= fragIndex;
            out.depth <= clampDepth(fragDepth);
            out.color <= '{r: clampColor(fragR), g: clampColor(fragG),
                           b: clampColor(fragB), a: clampColor(fragA)};
            depthIndexRead <= fragIndex;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            out.valid <= 1'b0;
        else
            out.valid <= fragValid;
    end

endmodule

/* logic/compareFunc.sv */
// Registered compare unit for the eight test functions
module compareFunc
#(
    parameter int width = 8
)
(
    input  logic clk,
    input  logic reset,
    input  pixelPkg::compareFuncE func,
    input  logic [width-1:0] val,
    input  logic [width-1:0] refVal,
    output logic pass
);

    // val is tested against refVal, one cycle of latency
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pass <= 1'b0;
        end
        else
        begin
            case (func)
                pixelPkg::cmpNever:        pass <= 1'b0;
                pixelPkg::cmpLess:         pass <= val < refVal;
                pixelPkg::cmpEqual:        pass <= val == refVal;
                pixelPkg::cmpLessEqual:    pass <= val <= refVal;
                pixelPkg::cmpGreater:      pass <= val > refVal;
                pixelPkg::cmpNotEqual:     pass <= val != refVal;
                pixelPkg::cmpGreaterEqual: pass <= val >= refVal;
                pixelPkg::cmpAlways:       pass <= 1'b1;
                default:                   pass <= 1'b0;
            endcase
        end
    end

endmodule

/* logic/fragmentTest.sv */
// Memory wait, alpha and depth test, and write-back stages
`include "pixelPipe_config.svh"

module fragmentTest
(
    input  logic clk,
    input  logic reset,
    fragmentIf.dst in,
    input  pixelPkg::depthT depthIn,
    input  pixelPkg::compareFuncE alphaFunc,
    input  logic [`SUB_PIXEL_WIDTH-1:0] alphaRef,
    input  pixelPkg::compareFuncE depthFunc,
    input  logic depthTestEnable,
    output pixelPkg::fbIndexT colorIndexWrite,
    output logic colorWriteEnable,
    output pixelPkg::pixelT colorOut,
    output pixelPkg::fbIndexT depthIndexWrite,
    output logic depthWriteEnable,
    output pixelPkg::depthT depthOut,
    output logic retire
);

    logic waitValid, testValid, resultValid;
    pixelPkg::fbIndexT waitIndex, testIndex, resultIndex;
    pixelPkg::depthT waitDepth, testDepth, resultDepth, storedDepth;
    pixelPkg::pixelT waitColor, testColor, resultColor;
    logic alphaPass, depthPass, writeColor;

    ////////////////////
    // Pipeline registers
    ////////////////////

    // Wait stage covers the synchronous read, depthIn is valid for the test stage
    always_ff @(posedge clk)
    begin
        if (in.valid)
        begin
            waitIndex <= in.fbIndex;
            waitDepth <= in.depth;
            waitColor <= in.color;
        end
        if (waitValid)
        begin
            testIndex <= waitIndex;
            testDepth <= waitDepth;
            testColor <= waitColor;
            storedDepth <= depthIn;
        end
        // Follows the compare units by one cycle
        resultIndex <= testIndex;
        resultDepth <= testDepth;
        resultColor <= testColor;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            waitValid <= 1'b0;
            testValid <= 1'b0;
            resultValid <= 1'b0;
        end
        else
        begin
            waitValid <= in.valid;
            testValid <= waitValid;
            resultValid <= testValid;
        end
    end

    compareFunc #(.width(`SUB_PIXEL_WIDTH)) i_alphaTest
    (
        .clk(clk), .reset(reset), .func(alphaFunc),
        .val(testColor.a), .refVal(alphaRef), .pass(alphaPass)
    );

    compareFunc #(.width(`DEPTH_WIDTH)) i_depthTest
    (
        .clk(clk), .reset(reset), .func(depthFunc),
        .val(testDepth), .refVal(storedDepth), .pass(depthPass)
    );

    ////////////////////
    // Write back
    ////////////////////

    // A disabled depth test lets every fragment through that passes alpha
    assign writeColor = resultValid & alphaPass & (depthPass | ~depthTestEnable);

    always_ff @(posedge clk)
    begin
        if (resultValid)
        begin
            colorIndexWrite <= resultIndex;
            depthIndexWrite <= resultIndex;
            colorOut <= resultColor;
            depthOut <= resultDepth;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            colorWriteEnable <= 1'b0;
            depthWriteEnable <= 1'b0;
            retire <= 1'b0;
        end
        else
        begin
            colorWriteEnable <= writeColor;
            depthWriteEnable <= writeColor & depthTestEnable;
            retire <= resultValid;
        end
    end

endmodule

/* logic/pixelTracker.sv */
// In-flight fragment counter
`include "pixelPipe_config.svh"

module pixelTracker
(
    input  logic clk,
    input  logic reset,
    input  logic accept,
    input  logic retire,
    output logic pixelInPipeline
);

    // One fragment can enter per cycle, so the latency bounds the count
    localparam int countWidth = $clog2(`PIPE_LATENCY + 1);

    logic [countWidth-1:0] count;

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (accept && !retire)
            count <= count + 1'b1;
        else if (!accept && retire)
            count <= count - 1'b1;
        // Accept and retire together cancel out
    end

    assign pixelInPipeline = |count;

endmodule

/* logic/pixelPipeline.sv */
// Pixel pipeline top level: clamp stage, test stages and in-flight tracker
`include "pixelPipe_config.svh"

module pixelPipeline
(
    input  logic clk,
    input  logic reset,

    // Fragment strobe
    input  logic fragValid,
    input  pixelPkg::fbIndexT fragIndex,
    input  logic [`DEPTH_IN_WIDTH-1:0] fragDepth,
    input  logic [`COLOR_IN_WIDTH-1:0] fragR,
    input  logic [`COLOR_IN_WIDTH-1:0] fragG,
    input  logic [`COLOR_IN_WIDTH-1:0] fragB,
    input  logic [`COLOR_IN_WIDTH-1:0] fragA,

    // Test configuration
    input  pixelPkg::compareFuncE alphaFunc,
    input  logic [`SUB_PIXEL_WIDTH-1:0] alphaRef,
    input  pixelPkg::compareFuncE depthFunc,
    input  logic depthTestEnable,

    // Depth buffer read, data one cycle after the address
    output pixelPkg::fbIndexT depthIndexRead,
    input  pixelPkg::depthT depthIn,

    // Color buffer write
    output pixelPkg::fbIndexT colorIndexWrite,
    output logic colorWriteEnable,
    output pixelPkg::pixelT colorOut,

    // Depth buffer write
    output pixelPkg::fbIndexT depthIndexWrite,
    output logic depthWriteEnable,
    output pixelPkg::depthT depthOut,

    output logic pixelInPipeline
);

    logic retire;

    fragmentIf fragBus ();

    fragmentClamp i_clamp
    (
        .clk(clk), .reset(reset),
        .fragValid(fragValid), .fragIndex(fragIndex), .fragDepth(fragDepth),
        .fragR(fragR), .fragG(fragG), .fragB(fragB), .fragA(fragA),
        .depthIndexRead(depthIndexRead),
        .out(fragBus.src)
    );

    fragmentTest i_test
    (
        .clk(clk), .reset(reset),
        .in(fragBus.dst),
        .depthIn(depthIn),
        .alphaFunc(alphaFunc), .alphaRef(alphaRef),
        .depthFunc(depthFunc), .depthTestEnable(depthTestEnable),
        .colorIndexWrite(colorIndexWrite), .colorWriteEnable(colorWriteEnable),
        .colorOut(colorOut),
        .depthIndexWrite(depthIndexWrite), .depthWriteEnable(depthWriteEnable),
        .depthOut(depthOut),
        .retire(retire)
    );

    // Every strobe is accepted
    pixelTracker i_tracker
    (
        .clk(clk), .reset(reset),
        .accept(fragValid), .retire(retire),
        .pixelInPipeline(pixelInPipeline)
    );

endmodule

/* tb/pixelPipeline_chk.sv */
// Bound assertions on the write-back outputs of the test stage
module pixelPipelineChk
(
    input logic clk,
    input logic reset,
    input logic colorWriteEnable,
    input logic depthWriteEnable,
    input logic depthTestEnable,
    input pixelPkg::fbIndexT colorIndexWrite,
    input pixelPkg::fbIndexT depthIndexWrite
);
    timeunit 1ns;
    timeprecision 100ps;

    // Read by the testbench top for the closing summary
    int assertFailures = 0;

    depthNeedsColor: assert property (@(posedge clk) disable iff (reset)
        depthWriteEnable |-> colorWriteEnable)
    else
    begin
        assertFailures++;
        $error("Depth write enable high without a color write enable");
    end

    depthNeedsEnable: assert property (@(posedge clk) disable iff (reset)
        depthWriteEnable |-> depthTestEnable)
    else
    begin
        assertFailures++;
        $error("Depth write enable high while the depth test is disabled");
    end

    // Both buffers are written at the same framebuffer position
    sameIndex: assert property (@(posedge clk) disable iff (reset)
        colorWriteEnable |-> (colorIndexWrite == depthIndexWrite))
    else
    begin
        assertFailures++;
        $error("Color and depth write indices differ");
    end

endmodule

bind fragmentTest pixelPipelineChk i_chk
(
    .clk(clk),
    .reset(reset),
    .colorWriteEnable(colorWriteEnable),
    .depthWriteEnable(depthWriteEnable),
    .depthTestEnable(depthTestEnable),
    .colorIndexWrite(colorIndexWrite),
    .depthIndexWrite(depthIndexWrite)
);

/* tb/pixelPipelineTb.sv */
// Pixel pipeline testbench: depth memory model, directed tests, checker and watchdog
`include "pixelPipe_config.svh"

module pixelPipelineTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 8;
    localparam int resetCycles = 8;
    localparam logic [31:0] seed = 32'hf4af_7f82;
    localparam int streamCount = 24;
    // Clamp, color, depth function and alpha function fragments
    localparam int directedFragments = 3 + 2 + 24 + 24;
    localparam int testCycles = resetCycles + directedFragments * (`PIPE_LATENCY + 2)
                                + streamCount + 3 * `PIPE_LATENCY;
    localparam int marginCycles = 200;

    logic clk, reset, fragValid, depthTestEnable;
    pixelPkg::fbIndexT fragIndex, depthIndexRead, colorIndexWrite, depthIndexWrite;
    logic [`DEPTH_IN_WIDTH-1:0] fragDepth;
    logic [`COLOR_IN_WIDTH-1:0] fragR, fragG, fragB, fragA;
    pixelPkg::compareFuncE alphaFunc, depthFunc;
    logic [`SUB_PIXEL_WIDTH-1:0] alphaRef;
    pixelPkg::depthT depthIn, depthOut;
    pixelPkg::pixelT colorOut;
    logic colorWriteEnable, depthWriteEnable, pixelInPipeline;

    pixelPkg::depthT depthMem [1 << `FB_INDEX_WIDTH];
    logic [31:0] rngState;
    int errorCount = 0;
    int checkCount = 0;
    int totalErrors;

    pixelPipeline i_dut (.*);

    always #(clkPeriod / 2) clk = ~clk;

    // Synchronous depth buffer, read data one edge after the address
    always @(posedge clk)
    begin
        depthIn <= depthMem[depthIndexRead];
        if (depthWriteEnable)
            depthMem[depthIndexWrite] <= depthOut;
    end

    ////////////////////
    // Reference rules
    ////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] depthRef(input logic [23:0] z);
        if ($signed(z) < 0)
            return 16'h0000;
        else if (z > 24'h00ffff)
            return 16'hffff;
        return z[15:0];
    endfunction

    function automatic logic [7:0] colorRef(input logic [15:0] c);
        return (c > 16'h00ff) ? 8'hff : c[7:0];
    endfunction

    // Function code bits 0, 1 and 2 accept less, equal and greater
    function automatic logic comparePass(input logic [2:0] func, input logic [15:0] val,
                                         input logic [15:0] refVal);
        return (func[0] && val < refVal) || (func[1] && val == refVal)
               || (func[2] && val > refVal);
    endfunction

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("FAIL %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic driveFragment(input pixelPkg::fbIndexT index, input logic [23:0] depth,
                                 input logic [15:0] r, g, b, a);
        fragValid = 1'b1;
        fragIndex = index;
        fragDepth = depth;
        fragR = r;
        fragG = g;
        fragB = b;
        fragA = a;
    endtask

    // One fragment through the pipeline with the current configuration
    task automatic processFragment(input string testName, input pixelPkg::fbIndexT index,
                                   input logic [23:0] depth, input logic [15:0] r, g, b, a);
        logic [15:0] expDepth;
        logic [31:0] expColor;
        logic expColorWrite, expDepthWrite;
        expDepth = depthRef(depth);
        expColor = {colorRef(r), colorRef(g), colorRef(b), colorRef(a)};
        expColorWrite = comparePass(alphaFunc, {8'h00, colorRef(a)}, {8'h00, alphaRef})
                        && (comparePass(depthFunc, expDepth, depthMem[index])
                        || !depthTestEnable);
        expDepthWrite = expColorWrite && depthTestEnable;
        driveFragment(index, depth, r, g, b, a);
        @(posedge clk);
        #1;
        fragValid = 1'b0;
        checkValue(testName, "read index", index, depthIndexRead);
        repeat (`PIPE_LATENCY - 2) @(posedge clk);
        #1;
        checkValue(testName, "early color write", 0, colorWriteEnable);
        @(posedge clk);
        #1;
        checkValue(testName, "color write enable", expColorWrite, colorWriteEnable);
        checkValue(testName, "depth write enable", expDepthWrite, depthWriteEnable);
        checkValue(testName, "in-flight flag", 1, pixelInPipeline);
        if (expColorWrite)
        begin
            checkValue(testName, "write index", index, colorIndexWrite);
            checkValue(testName, "color", expColor, colorOut);
            checkValue(testName, "depth", expDepth, depthOut);
        end
        if (expDepthWrite)
            checkValue(testName, "depth write index", index, depthIndexWrite);
        @(posedge clk);
        #1;
        checkValue(testName, "color write width", 0, colorWriteEnable);
        checkValue(testName, "depth write width", 0, depthWriteEnable);
        if (expDepthWrite)
            checkValue(testName, "stored depth", expDepth, depthMem[index]);
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic clampTest();
        alphaFunc = pixelPkg::cmpAlways;
        depthFunc = pixelPkg::cmpAlways;
        depthTestEnable = 1'b1;
        processFragment("depthNegative", 14'h0010, 24'hff8000,
                        16'h0010, 16'h0020, 16'h0030, 16'h0040);
        processFragment("depthAboveOne", 14'h0011, 24'h018000,
                        16'h0010, 16'h0020, 16'h0030, 16'h0040);
        processFragment("depthInRange", 14'h0012, 24'h001234,
                        16'h0010, 16'h0020, 16'h0030, 16'h0040);
        processFragment("colorClampA", 14'h0013, 24'h004000,
                        16'h0123, 16'h00ab, 16'hff00, 16'h0042);
        processFragment("colorClampB", 14'h0014, 24'h004000,
                        16'h00cd, 16'h0100, 16'h0077, 16'h01ff);
    endtask

    task automatic functionTest(input logic useDepth);
        pixelPkg::fbIndexT index;
        depthTestEnable = useDepth;
        alphaFunc = pixelPkg::cmpAlways;
        depthFunc = pixelPkg::cmpNever;
        alphaRef = 8'h80;
        for (int f = 0; f < 8; f++)
        begin
            for (int k = 0; k < 3; k++)
            begin
                index = 14'(16 * f + k + (useDepth ? 14'h0100 : 14'h0200));
                depthMem[index] = 16'h8000;
                if (useDepth)
                begin
                    depthFunc = pixelPkg::compareFuncE'(f);
                    processFragment($sformatf("depth %s", depthFunc.name()), index,
                                    24'h007fff + 24'(k), 16'h11, 16'h22, 16'h33, 16'h44);
                end
                else
                begin
                    alphaFunc = pixelPkg::compareFuncE'(f);
                    processFragment($sformatf("alpha %s", alphaFunc.name()), index,
                                    24'h001000, 16'h11, 16'h22, 16'h33, 16'h007f + 16'(k));
                end
            end
        end
    endtask

    // Back-to-back random fragments, one write per edge after the latency
    task automatic streamTest();
        pixelPkg::fbIndexT idx [streamCount];
        logic [23:0] depth [streamCount];
        logic [15:0] chan [streamCount][4];
        logic [15:0] expDepth [streamCount];
        logic [31:0] expColor [streamCount];
        logic expWrite [streamCount];
        alphaFunc = pixelPkg::cmpGreater;
        alphaRef = 8'h40;
        depthFunc = pixelPkg::cmpLessEqual;
        depthTestEnable = 1'b1;
        for (int i = 0; i < streamCount; i++)
        begin
            rngState = xorshift(rngState);
            idx[i] = {rngState[31:23], i[4:0]};
            depth[i] = rngState[0] ? {8'h00, rngState[15:0]} : rngState[23:0];
            for (int c = 0; c < 4; c++)
            begin
                rngState = xorshift(rngState);
                chan[i][c] = rngState[15:0] & 16'h01ff;
            end
            expDepth[i] = depthRef(depth[i]);
            expColor[i] = {colorRef(chan[i][0]), colorRef(chan[i][1]),
                           colorRef(chan[i][2]), colorRef(chan[i][3])};
            expWrite[i] = comparePass(alphaFunc, {8'h00, colorRef(chan[i][3])}, 16'h0040)
                          && comparePass(depthFunc, expDepth[i], depthMem[idx[i]]);
        end
        fork
            begin
                for (int i = 0; i < streamCount; i++)
                begin
                    driveFragment(idx[i], depth[i],
                                  chan[i][0], chan[i][1], chan[i][2], chan[i][3]);
                    @(posedge clk);
                    #1;
                end
                fragValid = 1'b0;
            end
            begin
                repeat (`PIPE_LATENCY - 1) @(posedge clk);
                #1;
                checkValue("stream", "early color write", 0, colorWriteEnable);
                for (int i = 0; i < streamCount; i++)
                begin
                    @(posedge clk);
                    #1;
                    checkValue("stream", "color write enable", expWrite[i], colorWriteEnable);
                    checkValue("stream", "depth write enable", expWrite[i], depthWriteEnable);
                    if (expWrite[i])
                    begin
                        checkValue("stream", "write index", idx[i], colorIndexWrite);
                        checkValue("stream", "color", expColor[i], colorOut);
                        checkValue("stream", "depth", expDepth[i], depthOut);
                    end
                end
            end
        join
        @(posedge clk);
        #1;
    endtask

    task automatic inFlightTest();
        checkValue("inFlight", "idle flag", 0, pixelInPipeline);
        driveFragment(14'h3000, 24'h000100, 16'h01, 16'h02, 16'h03, 16'h04);
        @(posedge clk);
        #1;
        checkValue("inFlight", "busy flag", 1, pixelInPipeline);
        fragIndex = 14'h3001;
        @(posedge clk);
        #1;
        fragValid = 1'b0;
        // Second fragment retires two edges after the first write-back
        repeat (`PIPE_LATENCY - 1) @(posedge clk)
        begin
            #1;
            checkValue("inFlight", "busy flag", 1, pixelInPipeline);
        end
        @(posedge clk);
        #1;
        checkValue("inFlight", "flag after last write", 0, pixelInPipeline);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        driveFragment('0, '0, '0, '0, '0, '0);
        fragValid = 1'b0;
        alphaFunc = pixelPkg::cmpAlways;
        alphaRef = '0;
        depthFunc = pixelPkg::cmpAlways;
        depthTestEnable = 1'b1;
        depthIn = '0;
        rngState = seed;
        for (int i = 0; i < (1 << `FB_INDEX_WIDTH); i++)
            depthMem[i] = 16'(i * 40503) ^ 16'hc3a5;
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
        checkValue("reset", "in-flight flag", 0, pixelInPipeline);
        clampTest();
        functionTest(1'b1);
        functionTest(1'b0);
        streamTest();
        inFlightTest();
        totalErrors = errorCount + i_dut.i_test.i_chk.assertFailures;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, i_dut.i_test.i_chk.assertFailures);
        if (totalErrors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // Watchdog
    initial
    begin
        #((testCycles + marginCycles) * clkPeriod);
        $display("Watchdog timeout: the tests did not finish in the expected time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* build.f */
+incdir+logic
logic/pixelPkg.sv
logic/fragmentIf.sv
logic/fragmentClamp.sv
logic/compareFunc.sv
logic/fragmentTest.sv
logic/pixelTracker.sv
logic/pixelPipeline.sv
tb/pixelPipeline_chk.sv
tb/pixelPipelineTb.sv
